// ==== hdl/dbus_settings.svh ====
`ifndef DBUS_SETTINGS_SVH
`define DBUS_SETTINGS_SVH

// address region field, top five bits of the word address
`define DBUS_REGION_LSB 27
`define DBUS_REGION_RAM 5'd2
`define DBUS_REGION_PORTS 5'd31

// 256 words of RAM
`define DBUS_RAM_BITS 8

// byte lanes per bus word
`define DBUS_LANES 4

// free-running timer, wraps every 1024 cycles
`define DBUS_TIMER_BITS 10

`endif

// ==== hdl/dbus_pkg.sv ====
package dbus_pkg;

    `include "dbus_settings.svh"

    // one bus word
    typedef logic [31:0] word_t;

    // one byte lane
    typedef logic [7:0] byte_t;

    // region field of the address
    typedef logic [4:0] region_t;

    // word index into each RAM lane
    typedef logic [`DBUS_RAM_BITS-1:0] ram_index_t;

    // decoder phase
    typedef enum logic {
        PHASE_IDLE,
        PHASE_RESPOND
    } bus_phase_t;

endpackage

// ==== hdl/lane_if.sv ====
`timescale 1ns/10ps

`include "dbus_settings.svh"

interface lane_if import dbus_pkg::*; ();

    logic strobe;
    logic write_enable;
    ram_index_t index;
    byte_t write_byte;
    byte_t read_byte;

    modport decoder (
        output strobe,
        output write_enable,
        output index,
        output write_byte
    );

    modport lane (
        input strobe,
        input write_enable,
        input index,
        input write_byte,
        output read_byte
    );

    // merger only needs the returned byte
    modport merge (
        input read_byte
    );

endinterface

// ==== hdl/bus_decoder.sv ====
`timescale 1ns/10ps

`include "dbus_settings.svh"

module bus_decoder import dbus_pkg::*; (
    input logic cpu_clk,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_we,
    input logic [`DBUS_LANES-1:0] wb_sel,
    input word_t wb_adr,
    input word_t wb_dat_w,
    output logic wb_ack,
    output logic wb_err,
    lane_if.decoder lanes [0:`DBUS_LANES-1],
    output logic port_strobe,
    output logic port_write,
    output logic [`DBUS_LANES-1:0] port_sel,
    output word_t port_data,
    output region_t response_region
);

    bus_phase_t phase;
    region_t region;
    logic request;
    logic ram_hit;
    logic port_hit;

    assign region = wb_adr[31:`DBUS_REGION_LSB];

    // only accept while idle, so a held strobe can't double up
    assign request = (phase == PHASE_IDLE) && wb_cyc && wb_stb;
    assign ram_hit = request && (region == `DBUS_REGION_RAM);
    assign port_hit = request && (region == `DBUS_REGION_PORTS);

    genvar i;
    generate
        for (i = 0; i < `DBUS_LANES; i = i + 1) begin : g_lane_drive
            assign lanes[i].strobe = ram_hit;
            assign lanes[i].write_enable = wb_we & wb_sel[i];
            assign lanes[i].index = wb_adr[`DBUS_RAM_BITS+1:2];
            assign lanes[i].write_byte = wb_dat_w[8*i +: 8];
        end
    endgenerate

    assign port_strobe = port_hit;
    assign port_write = wb_we;
    assign port_sel = wb_sel;
    assign port_data = wb_dat_w;

    always_ff @(posedge cpu_clk) begin
        if (!reset) begin
            phase <= PHASE_IDLE;
            wb_ack <= 1'b0;
            wb_err <= 1'b0;
        end else begin
            wb_ack <= ram_hit | port_hit;
            // unmapped region answers with err
            wb_err <= request & ~(ram_hit | port_hit);
            case (phase)
                PHASE_IDLE: begin
                    if (request) begin
                        phase <= PHASE_RESPOND;
                    end
                end
                PHASE_RESPOND: begin
                    phase <= PHASE_IDLE;
                end
                default: begin
                    phase <= PHASE_IDLE;
                end
            endcase
        end
    end

    // read source for the merger
    always_ff @(posedge cpu_clk) begin
        if (request) begin
            response_region <= region;
        end
    end

endmodule

// ==== hdl/ram_lane.sv ====
`timescale 1ns/10ps

`include "dbus_settings.svh"

module ram_lane import dbus_pkg::*; (
    input logic cpu_clk,
    lane_if.lane lane
);

    localparam int DEPTH = 1 << `DBUS_RAM_BITS;

    byte_t mem [0:DEPTH-1];

    // read returns the old byte when a write hits the same index
    always_ff @(posedge cpu_clk) begin
        if (lane.strobe) begin
            if (lane.write_enable) begin
                mem[lane.index] <= lane.write_byte;
            end
            lane.read_byte <= mem[lane.index];
        end
    end

endmodule

// ==== hdl/port_block.sv ====
`timescale 1ns/10ps

`include "dbus_settings.svh"

module port_block import dbus_pkg::*; (
    input logic cpu_clk,
    input logic reset,
    input logic port_strobe,
    input logic port_write,
    input logic [`DBUS_LANES-1:0] port_sel,
    input word_t port_data,
    input logic con_button,
    input logic psh_button,
    input logic tra,
    input logic trb,
    input logic bak_button,
    input logic scl_line,
    input logic sda_line,
    output logic led,
    output logic scl_drive,
    output logic sda_drive,
    output logic timer_irq,
    output word_t port_word
);

    logic [`DBUS_TIMER_BITS-1:0] timer_count;
    logic irq_clear;

    assign irq_clear = port_strobe && port_write && port_sel[1] && port_data[8];

    // lines idle high, led off
    always_ff @(posedge cpu_clk) begin
        if (!reset) begin
            led <= 1'b1;
            scl_drive <= 1'b1;
            sda_drive <= 1'b1;
        end else if (port_strobe && port_write && port_sel[0]) begin
            {led, scl_drive, sda_drive} <= port_data[2:0];
        end
    end

    always_ff @(posedge cpu_clk) begin
        if (!reset) begin
            timer_count <= '0;
            timer_irq <= 1'b0;
        end else begin
            timer_count <= timer_count + 1'b1;
            // wrap sets the flag, set wins over clear
            if (timer_count == {`DBUS_TIMER_BITS{1'b1}}) begin
                timer_irq <= 1'b1;
            end else if (irq_clear) begin
                timer_irq <= 1'b0;
            end
        end
    end

    // sampled inputs, bit 7 left clear
    always_ff @(posedge cpu_clk) begin
        if (port_strobe) begin
            port_word <= {23'b0, timer_irq, 1'b0, con_button, psh_button, tra, trb,
                          bak_button, scl_line, sda_line};
        end
    end

endmodule

// ==== hdl/read_merge.sv ====
`timescale 1ns/10ps

`include "dbus_settings.svh"

module read_merge import dbus_pkg::*; (
    lane_if.merge lanes [0:`DBUS_LANES-1],
    input word_t port_word,
    input region_t response_region,
    output word_t wb_dat_r
);

    word_t lane_word;

    // lane 0 is the low byte
    genvar i;
    generate
        for (i = 0; i < `DBUS_LANES; i = i + 1) begin : g_lane_collect
            assign lane_word[8*i +: 8] = lanes[i].read_byte;
        end
    endgenerate

    always_comb begin
        if (response_region == `DBUS_REGION_RAM) begin
            wb_dat_r = lane_word;
        end else begin
            wb_dat_r = port_word;
        end
    end

endmodule

// ==== hdl/dbus_top.sv ====
`timescale 1ns/10ps

`include "dbus_settings.svh"

module dbus_top import dbus_pkg::*; (
    input logic cpu_clk,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_we,
    input logic [`DBUS_LANES-1:0] wb_sel,
    input word_t wb_adr,
    input word_t wb_dat_w,
    output word_t wb_dat_r,
    output logic wb_ack,
    output logic wb_err,
    input logic con_button,
    input logic psh_button,
    input logic tra,
    input logic trb,
    input logic bak_button,
    input logic scl_line,
    input logic sda_line,
    output logic led,
    output logic scl_drive,
    output logic sda_drive,
    output logic timer_irq
);

    logic port_strobe;
    logic port_write;
    logic [`DBUS_LANES-1:0] port_sel;
    word_t port_data;
    word_t port_word;
    region_t response_region;

    lane_if lanes [0:`DBUS_LANES-1] ();

    bus_decoder u_decoder (
        .cpu_clk(cpu_clk),
        .reset(reset),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_sel(wb_sel),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_ack(wb_ack),
        .wb_err(wb_err),
        .lanes(lanes),
        .port_strobe(port_strobe),
        .port_write(port_write),
        .port_sel(port_sel),
        .port_data(port_data),
        .response_region(response_region)
    );

    genvar i;
    generate
        for (i = 0; i < `DBUS_LANES; i = i + 1) begin : g_ram
            ram_lane u_lane (
                .cpu_clk(cpu_clk),
                .lane(lanes[i])
            );
        end
    endgenerate

    port_block u_ports (
        .cpu_clk(cpu_clk),
        .reset(reset),
        .port_strobe(port_strobe),
        .port_write(port_write),
        .port_sel(port_sel),
        .port_data(port_data),
        .con_button(con_button),
        .psh_button(psh_button),
        .tra(tra),
        .trb(trb),
        .bak_button(bak_button),
        .scl_line(scl_line),
        .sda_line(sda_line),
        .led(led),
        .scl_drive(scl_drive),
        .sda_drive(sda_drive),
        .timer_irq(timer_irq),
        .port_word(port_word)
    );

    read_merge u_merge (
        .lanes(lanes),
        .port_word(port_word),
        .response_region(response_region),
        .wb_dat_r(wb_dat_r)
    );

endmodule

// ==== verification/tb_dbus.sv ====
`timescale 1ns/10ps

`include "dbus_settings.svh"

module tb_dbus import dbus_pkg::*; ();

    localparam int RAM_WORDS = 1 << `DBUS_RAM_BITS;
    localparam int BUS_TIMEOUT = 8;
    localparam int IRQ_TIMEOUT = (1 << `DBUS_TIMER_BITS) + 16;

    logic cpu_clk;
    logic reset;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [3:0] wb_sel;
    word_t wb_adr;
    word_t wb_dat_w;
    word_t wb_dat_r;
    logic wb_ack;
    logic wb_err;
    logic con_button;
    logic psh_button;
    logic tra;
    logic trb;
    logic bak_button;
    logic scl_line;
    logic sda_line;
    logic led;
    logic scl_drive;
    logic sda_drive;
    logic timer_irq;

    // reference state
    word_t ram_model [0:RAM_WORDS-1];
    logic written [0:RAM_WORDS-1];
    logic [2:0] drive_model;
    logic [`DBUS_TIMER_BITS-1:0] timer_model;
    logic irq_model;
    logic irq_clear_pending;
    logic [31:0] rng_state;

    dbus_top u_dut (.*);

    initial begin
        cpu_clk = 1'b0;
        forever #10 cpu_clk = ~cpu_clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic word_t region_address(input region_t region, input ram_index_t idx);
        word_t adr;
        adr = '0;
        adr[31:`DBUS_REGION_LSB] = region;
        adr[`DBUS_RAM_BITS+1:2] = idx;
        return adr;
    endfunction

    // expected read word from the RAM model or the port inputs and irq flag
    function automatic word_t expected_word(input word_t adr);
        word_t word;
        word = '0;
        if (adr[31:`DBUS_REGION_LSB] == `DBUS_REGION_RAM) begin
            word = ram_model[adr[`DBUS_RAM_BITS+1:2]];
        end else if (adr[31:`DBUS_REGION_LSB] == `DBUS_REGION_PORTS) begin
            word[8] = irq_model;
            word[6:0] = {con_button, psh_button, tra, trb, bak_button, scl_line, sda_line};
        end
        return word;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        $display("TEST FAILED");
        $fatal(1, "wait timed out");
    endtask

    // flag sets the cycle after an all-ones count and beats a clear
    always @(posedge cpu_clk) begin
        if (!reset) begin
            timer_model <= '0;
            irq_model <= 1'b0;
        end else begin
            timer_model <= timer_model + 1'b1;
            if (timer_model == {`DBUS_TIMER_BITS{1'b1}}) begin
                irq_model <= 1'b1;
            end else if (irq_clear_pending) begin
                irq_model <= 1'b0;
            end
        end
    end

    always @(negedge cpu_clk) begin
        if (reset) begin
            check_value("timer irq", {31'b0, irq_model}, {31'b0, timer_irq});
        end
    end

    task automatic run_cycle(input string name, input logic we, input logic [3:0] sel,
                             input word_t adr, input word_t dat, input logic expect_err,
                             output word_t rdata, output word_t expected);
        int cycles;
        logic responded;
        @(posedge cpu_clk);
        #2;
        {wb_cyc, wb_stb, wb_we} = {2'b11, we};
        wb_sel = sel;
        wb_adr = adr;
        wb_dat_w = dat;
        irq_clear_pending = we && (adr[31:`DBUS_REGION_LSB] == `DBUS_REGION_PORTS)
                            && sel[1] && dat[8];
        expected = expected_word(adr);
        cycles = 0;
        responded = 1'b0;
        while (!responded) begin
            @(posedge cpu_clk);
            #1;
            cycles = cycles + 1;
            if (wb_ack || wb_err) begin
                responded = 1'b1;
            end else if (cycles >= BUS_TIMEOUT) begin
                report_timeout({name, " got no ack or err"});
            end
        end
        irq_clear_pending = 1'b0;
        check_value({name, " latency"}, 1, cycles);
        check_value({name, " err"}, {31'b0, expect_err}, {31'b0, wb_err});
        check_value({name, " ack"}, {31'b0, ~expect_err}, {31'b0, wb_ack});
        rdata = wb_dat_r;
        #1;
        {wb_cyc, wb_stb, wb_we} = 3'b000;
        @(posedge cpu_clk);
        #1;
        // response lasts one cycle only
        check_value({name, " response end"}, 0, {30'b0, wb_ack, wb_err});
    endtask

    task automatic write_word(input string name, input logic [3:0] sel, input word_t adr,
                              input word_t dat, input logic expect_err);
        word_t rdata;
        word_t expected;
        run_cycle(name, 1'b1, sel, adr, dat, expect_err, rdata, expected);
        if (!expect_err && adr[31:`DBUS_REGION_LSB] == `DBUS_REGION_RAM) begin
            for (int lane = 0; lane < `DBUS_LANES; lane++) begin
                if (sel[lane]) begin
                    ram_model[adr[`DBUS_RAM_BITS+1:2]][8*lane +: 8] = dat[8*lane +: 8];
                end
            end
        end
        if (!expect_err && adr[31:`DBUS_REGION_LSB] == `DBUS_REGION_PORTS && sel[0]) begin
            drive_model = dat[2:0];
        end
    endtask

    task automatic read_word(input string name, input word_t adr, input logic expect_err,
                             output word_t rdata);
        word_t expected;
        run_cycle(name, 1'b0, 4'h0, adr, 32'h0, expect_err, rdata, expected);
        if (!expect_err) begin
            check_value(name, expected, rdata);
        end
    endtask

    initial begin
        word_t rdata;
        word_t port_adr;
        ram_index_t idx;
        logic [31:0] value;
        region_t bad_regions [0:2];
        int cycles;
        {wb_cyc, wb_stb, wb_we} = 3'b000;
        wb_sel = 4'h0;
        wb_adr = '0;
        wb_dat_w = '0;
        {con_button, psh_button, tra, trb, bak_button, scl_line, sda_line} = 7'h00;
        irq_clear_pending = 1'b0;
        rng_state = 32'd77;
        drive_model = 3'b111;
        bad_regions = '{5'd0, 5'd1, 5'd30};
        port_adr = region_address(`DBUS_REGION_PORTS, '0);
        reset = 1'b0;
        repeat (16) @(posedge cpu_clk);
        #2;
        reset = 1'b1;
        // ack, err and irq low with the drives high
        check_value("reset state", 32'h07,
                    {26'b0, wb_ack, wb_err, timer_irq, led, scl_drive, sda_drive});

        for (int i = 0; i < RAM_WORDS; i++) begin
            idx = i;
            written[i] = 1'b0;
            write_word("ram fill", 4'hf, region_address(`DBUS_REGION_RAM, idx),
                       {idx, ~idx, idx ^ 8'h5a, idx + 8'h33}, 1'b0);
        end
        for (int i = 0; i < 64; i++) begin
            value = next_random();
            idx = value[`DBUS_RAM_BITS+7:8];
            written[idx] = 1'b1;
            write_word("ram write", value[3:0], region_address(`DBUS_REGION_RAM, idx),
                       next_random(), 1'b0);
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            if (written[i]) begin
                read_word("ram readback", region_address(`DBUS_REGION_RAM, i), 1'b0, rdata);
            end
        end

        foreach (bad_regions[r]) begin
            idx = next_random();
            write_word("unmapped write", 4'hf, region_address(bad_regions[r], idx),
                       next_random(), 1'b1);
            read_word("unmapped read", region_address(bad_regions[r], idx), 1'b1, rdata);
            read_word("ram after unmapped", region_address(`DBUS_REGION_RAM, idx), 1'b0, rdata);
        end

        for (int i = 0; i < 8; i++) begin
            write_word("port drive write", 4'h1, port_adr, next_random() & 32'hfffffeff, 1'b0);
            check_value("port drive", {29'b0, drive_model}, {29'b0, led, scl_drive, sda_drive});
            @(posedge cpu_clk);
            #2;
            {con_button, psh_button, tra, trb, bak_button, scl_line, sda_line} = next_random();
            read_word("port read", port_adr, 1'b0, rdata);
        end

        // flag has long been set, so clear it and wait for a fresh rise
        write_word("irq pre clear", 4'h2, port_adr, 32'h100, 1'b0);
        cycles = 0;
        while (!timer_irq) begin
            @(posedge cpu_clk);
            #1;
            cycles = cycles + 1;
            if (cycles > IRQ_TIMEOUT) begin
                report_timeout("timer_irq never went high");
            end
        end
        read_word("irq port read", port_adr, 1'b0, rdata);
        check_value("irq read bit", 32'h1, {31'b0, rdata[8]});
        write_word("irq clear", 4'h2, port_adr, 32'h100, 1'b0);
        check_value("irq cleared", 32'h0, {31'b0, timer_irq});
        check_value("drive after clear", {29'b0, drive_model},
                    {29'b0, led, scl_drive, sda_drive});

        $display("TEST OK");
        $finish;
    end

endmodule

// ==== dbus_soc.f ====
+incdir+hdl
hdl/dbus_pkg.sv
hdl/lane_if.sv
hdl/bus_decoder.sv
hdl/ram_lane.sv
hdl/port_block.sv
hdl/read_merge.sv
hdl/dbus_top.sv
verification/tb_dbus.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the dbus testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f dbus_soc.f --top-module tb_dbus -o tb_dbus \
    && ./obj_dir/tb_dbus \
    || { echo "simulation run failed"; exit 1; }
